//--- all.f
+incdir+verilog
verilog/cache_pkg.sv
verilog/cache_way.sv
verilog/refill_buffer.sv
verilog/read_data_sel.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
testbench/tb_mem_model.sv
testbench/tb_cache_top.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator and run, exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f all.f --top-module tb_cache_top -o sim_cache &&
./obj_dir/sim_cache &&
echo "simulation finished without error" ||
{ echo "simulation failed"; exit 1; }

//--- testbench/tb_cache_top.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module tb_cache_top import cache_pkg::*; ();

    localparam int reset_cycles = 8;
    localparam int num_reqs     = 213;      // directed plus random
    localparam int max_cycles   = 20 * num_reqs + reset_cycles + 10;

    logic                     aclk;
    logic                     rst_n_i;
    logic                     valid_i;
    cpu_req_t                 cpu_req_i;
    logic                     addr_ok_o;
    logic                     data_ok_o;
    logic [`CACHE_WORD_W-1:0] rdata_o;
    logic                     rd_req_o;
    mem_rd_t                  rd_o;
    logic                     rd_rdy_i;
    logic                     ret_valid_i;
    logic                     ret_last_i;
    logic [`CACHE_WORD_W-1:0] ret_data_i;

    // model of the tag store
    logic [`CACHE_TAG_W-1:0]  ref_tag   [0:1][0:`CACHE_SETS-1];
    logic                     ref_valid [0:1][0:`CACHE_SETS-1];
    logic                     ref_ptr   [0:`CACHE_SETS-1];     // way to fill next

    string                    test_name;
    logic [`CACHE_WORD_W-1:0] exp_word;
    logic                     exp_hit;
    mem_rd_t                  exp_cmd_q [$];
    int                       cyc            = 0;
    int                       acc_cyc        = 0;
    int                       req_cnt        = 0;
    int                       resp_cnt       = 0;
    logic                     rd_req_prev    = 1'b0;
    logic                     last_beat_prev = 1'b0;   // last beat seen in the previous cycle
    integer                   seed;
    logic [31:0]              rnd;

    cache_top cache_top_i (
        .aclk        (aclk),
        .rst_n_i     (rst_n_i),
        .valid_i     (valid_i),
        .cpu_req_i   (cpu_req_i),
        .addr_ok_o   (addr_ok_o),
        .data_ok_o   (data_ok_o),
        .rdata_o     (rdata_o),
        .rd_req_o    (rd_req_o),
        .rd_o        (rd_o),
        .rd_rdy_i    (rd_rdy_i),
        .ret_valid_i (ret_valid_i),
        .ret_last_i  (ret_last_i),
        .ret_data_i  (ret_data_i)
    );

    tb_mem_model mem_model_i (
        .aclk        (aclk),
        .rst_n_i     (rst_n_i),
        .rd_req_i    (rd_req_o),
        .rd_i        (rd_o),
        .rd_rdy_o    (rd_rdy_i),
        .ret_valid_o (ret_valid_i),
        .ret_last_o  (ret_last_i),
        .ret_data_o  (ret_data_i)
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    //////////////////////////////////////////////////
    // checks and reference
    //////////////////////////////////////////////////
    task automatic check_equal(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("error: %s expected %0h actual %0h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic fail_with(input string what);
        $display("%s (%s)", what, test_name);
        $display("Test FAILED");
        $fatal(1, "protocol failure");
    endtask

    function automatic logic [`CACHE_WORD_W-1:0] mem_word(input logic [`CACHE_ADDR_W-1:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h5A5A0000;
    endfunction

    function automatic cpu_req_t make_req(input logic [`CACHE_TAG_W-1:0] tag,
                                          input logic [`CACHE_INDEX_W-1:0] index,
                                          input logic [`CACHE_OFFSET_W-1:0] offset,
                                          input logic uncached);
        cpu_req_t req;
        req.tag      = tag;
        req.index    = index;
        req.offset   = offset;
        req.uncached = uncached;
        return req;
    endfunction

    // expected word and memory command, updates the tag model
    function automatic logic [`CACHE_WORD_W-1:0] expected_read(input cpu_req_t req,
                                                               output logic cmd_exp,
                                                               output mem_rd_t cmd);
        logic [`CACHE_ADDR_W-1:0] byte_addr;
        logic                     hit;
        int                       way;
        byte_addr = {req.tag, req.index, req.offset};
        hit       = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[w][req.index] && ref_tag[w][req.index] == req.tag) begin
                hit = 1'b1;
            end
        end
        cmd_exp     = req.uncached || !hit;
        cmd.rd_type = req.uncached ? rd_word : rd_line;
        cmd.addr    = req.uncached ? byte_addr : {byte_addr[31:4], 4'h0};
        if (!req.uncached && !hit) begin
            way                      = ref_ptr[req.index] ? 1 : 0;
            ref_valid[way][req.index] = 1'b1;
            ref_tag[way][req.index]   = req.tag;
            ref_ptr[req.index]        = !ref_ptr[req.index];    // ways fill in turn
        end
        return mem_word(byte_addr);
    endfunction

    task automatic send_req(input cpu_req_t req);
        logic    cmd_exp;
        mem_rd_t cmd;
        exp_word = expected_read(req, cmd_exp, cmd);
        exp_hit  = !cmd_exp;
        if (cmd_exp) begin
            exp_cmd_q.push_back(cmd);
        end
        valid_i   = 1'b1;
        cpu_req_i = req;
        @(negedge aclk);
        while (!addr_ok_o) begin
            @(negedge aclk);
        end
        acc_cyc = cyc;                  // accepted at the next rising edge
        req_cnt++;
        @(posedge aclk);
        #1;
        valid_i = 1'b0;
        while (resp_cnt != req_cnt) begin
            @(posedge aclk);
        end
        #1;
    endtask

    //////////////////////////////////////////////////
    // compare process, sampled mid cycle
    //////////////////////////////////////////////////
    always @(negedge aclk) begin
        if (rst_n_i) begin
            if (rd_req_o && !rd_req_prev) begin
                check_equal(test_name, 64'(acc_cyc + 2), 64'(cyc));
            end
            if (rd_req_o && rd_rdy_i) begin
                if (exp_cmd_q.size() == 0) begin
                    fail_with("memory read issued for a request that should hit");
                end else begin
                    check_equal(test_name, 64'(exp_cmd_q.pop_front()), 64'(rd_o));
                end
            end
            if (data_ok_o) begin
                if (resp_cnt >= req_cnt) begin
                    fail_with("data_ok_o without an accepted request");
                end else begin
                    check_equal(test_name, 64'(exp_word), 64'(rdata_o));
                    check_equal(test_name, 64'(0), 64'(exp_cmd_q.size()));
                    if (exp_hit) begin
                        check_equal(test_name, 64'(acc_cyc + 1), 64'(cyc));   // hit latency
                    end else begin
                        check_equal(test_name, 64'(1), 64'(last_beat_prev));  // after last beat
                    end
                    resp_cnt++;
                end
            end
        end
        rd_req_prev    = rd_req_o;
        last_beat_prev = ret_valid_i && ret_last_i;
    end

    always @(posedge aclk) begin
        cyc <= cyc + 1;
        if (cyc > max_cycles) begin
            $display("timeout: run still busy after %0d cycles", cyc);
            $display("Test FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    initial begin
        rst_n_i   = 1'b0;
        valid_i   = 1'b0;
        cpu_req_i = '0;
        seed      = 85267;
        test_name = "reset";
        for (int s = 0; s < `CACHE_SETS; s++) begin
            ref_valid[0][s] = 1'b0;
            ref_valid[1][s] = 1'b0;
            ref_ptr[s]      = 1'b0;
        end
        repeat (reset_cycles) @(posedge aclk);
        #1;
        rst_n_i = 1'b1;
        @(negedge aclk);
        check_equal(test_name, 64'(1), 64'(addr_ok_o));
        check_equal(test_name, 64'(0), 64'(data_ok_o));
        check_equal(test_name, 64'(0), 64'(rd_req_o));
        @(posedge aclk);
        #1;

        test_name = "first_miss";
        send_req(make_req(20'h12345, 8'h01, 4'h4, 1'b0));
        test_name = "line_hits";
        send_req(make_req(20'h12345, 8'h01, 4'h0, 1'b0));
        send_req(make_req(20'h12345, 8'h01, 4'h8, 1'b0));
        send_req(make_req(20'h12345, 8'h01, 4'hc, 1'b0));

        test_name = "three_tags";               // A B C A all miss
        send_req(make_req(20'h0000a, 8'h02, 4'h0, 1'b0));
        send_req(make_req(20'h0000b, 8'h02, 4'h4, 1'b0));
        send_req(make_req(20'h0000c, 8'h02, 4'h8, 1'b0));
        send_req(make_req(20'h0000a, 8'h02, 4'hc, 1'b0));
        test_name = "two_tags";                 // A B A, last one hits
        send_req(make_req(20'h0000a, 8'h03, 4'h0, 1'b0));
        send_req(make_req(20'h0000b, 8'h03, 4'h4, 1'b0));
        send_req(make_req(20'h0000a, 8'h03, 4'h8, 1'b0));

        test_name = "uncached";
        send_req(make_req(20'h0f00d, 8'h05, 4'hb, 1'b1));
        send_req(make_req(20'h0f00d, 8'h05, 4'h8, 1'b0));

        test_name = "random";
        for (int n = 0; n < 200; n++) begin
            rnd = $random(seed);
            send_req(make_req({18'h3a5c7, rnd[1:0]}, {6'h04, rnd[3:2]}, rnd[7:4],
                              rnd[10:8] == 3'b000));
        end

        repeat (4) @(posedge aclk);
        $display("Test OK");
        $finish;
    end

endmodule

//--- testbench/tb_mem_model.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module tb_mem_model import cache_pkg::*; (
    input  logic                     aclk,
    input  logic                     rst_n_i,
    input  logic                     rd_req_i,
    input  mem_rd_t                  rd_i,
    output logic                     rd_rdy_o,
    output logic                     ret_valid_o,
    output logic                     ret_last_o,
    output logic [`CACHE_WORD_W-1:0] ret_data_o
);

    integer  seed;
    mem_rd_t cmd;           // command taken at the ready edge
    int      beats;

    // contents of the word that holds byte address addr
    function automatic logic [`CACHE_WORD_W-1:0] mem_word(
        input logic [`CACHE_ADDR_W-1:0] addr
    );
        return {addr[31:2], 2'b00} ^ 32'h5A5A0000;
    endfunction

    // zero to three empty cycles
    task automatic idle_gap();
        int gap;
        gap = $random(seed) & 3;
        repeat (gap) begin
            @(posedge aclk);
            #1;
        end
    endtask

    //////////////////////////////////////////////////
    // responder, one command at a time
    //////////////////////////////////////////////////
    initial begin
        seed        = 85267;
        rd_rdy_o    = 1'b0;
        ret_valid_o = 1'b0;
        ret_last_o  = 1'b0;
        ret_data_o  = '0;
        forever begin
            @(posedge aclk);
            #1;
            if (rst_n_i && rd_req_i) begin
                idle_gap();                 // back-pressure on the command
                rd_rdy_o = 1'b1;
                cmd      = rd_i;
                @(posedge aclk);
                #1;
                rd_rdy_o = 1'b0;
                beats    = (cmd.rd_type == rd_line) ? `CACHE_LINE_WORDS : 1;
                for (int b = 0; b < beats; b++) begin
                    idle_gap();             // gap before each beat
                    ret_valid_o = 1'b1;
                    ret_last_o  = (b == beats - 1);
                    ret_data_o  = mem_word(cmd.addr + 4 * b);
                    @(posedge aclk);
                    #1;
                    ret_valid_o = 1'b0;
                    ret_last_o  = 1'b0;
                end
            end
        end
    end

endmodule

//--- verilog/cache_top.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_top import cache_pkg::*; (
    input  logic                     aclk,
    input  logic                     rst_n_i,
    // processor port
    input  logic                     valid_i,
    input  cpu_req_t                 cpu_req_i,
    output logic                     addr_ok_o,
    output logic                     data_ok_o,
    output logic [`CACHE_WORD_W-1:0] rdata_o,
    // memory read port
    output logic                     rd_req_o,
    output mem_rd_t                  rd_o,
    input  logic                     rd_rdy_i,
    input  logic                     ret_valid_i,
    input  logic                     ret_last_i,
    input  logic [`CACHE_WORD_W-1:0] ret_data_i
);

    cpu_req_t    lookup_req;        // registered request
    logic        hit0;
    logic        hit1;
    logic        fill_we0;
    logic        fill_we1;
    logic        refill_start;
    logic        sel_refill;
    cache_line_t way0_line;
    cache_line_t way1_line;
    cache_line_t refill_line;

    //////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////
    cache_ctrl cache_ctrl_i (
        .aclk           (aclk),
        .rst_n_i        (rst_n_i),
        .valid_i        (valid_i),
        .cpu_req_i      (cpu_req_i),
        .addr_ok_o      (addr_ok_o),
        .data_ok_o      (data_ok_o),
        .rd_req_o       (rd_req_o),
        .rd_o           (rd_o),
        .rd_rdy_i       (rd_rdy_i),
        .ret_valid_i    (ret_valid_i),
        .ret_last_i     (ret_last_i),
        .lookup_req_o   (lookup_req),
        .hit0_i         (hit0),
        .hit1_i         (hit1),
        .fill_we0_o     (fill_we0),
        .fill_we1_o     (fill_we1),
        .refill_start_o (refill_start),
        .sel_refill_o   (sel_refill)
    );

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////
    cache_way way0_i (
        .aclk      (aclk),
        .rst_n_i   (rst_n_i),
        .index_i   (lookup_req.index),
        .tag_i     (lookup_req.tag),
        .hit_o     (hit0),
        .line_o    (way0_line),
        .we_i      (fill_we0),
        .wr_line_i (refill_line)
    );

    cache_way way1_i (
        .aclk      (aclk),
        .rst_n_i   (rst_n_i),
        .index_i   (lookup_req.index),
        .tag_i     (lookup_req.tag),
        .hit_o     (hit1),
        .line_o    (way1_line),
        .we_i      (fill_we1),
        .wr_line_i (refill_line)
    );

    refill_buffer refill_buffer_i (
        .aclk        (aclk),
        .rst_n_i     (rst_n_i),
        .start_i     (refill_start),
        .ret_valid_i (ret_valid_i),
        .ret_data_i  (ret_data_i),
        .line_o      (refill_line)
    );

    read_data_sel read_data_sel_i (
        .sel_refill_i  (sel_refill),
        .uncache_i     (lookup_req.uncached),
        .word_i        (lookup_req.offset[`CACHE_OFFSET_W-1 -: `CACHE_WORD_SEL_W]),
        .hit0_i        (hit0),
        .hit1_i        (hit1),
        .way0_line_i   (way0_line),
        .way1_line_i   (way1_line),
        .refill_line_i (refill_line),
        .rdata_o       (rdata_o)
    );

endmodule

//--- verilog/cache_ctrl.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_ctrl import cache_pkg::*; (
    input  logic     aclk,
    input  logic     rst_n_i,
    input  logic     valid_i,
    input  cpu_req_t cpu_req_i,
    output logic     addr_ok_o,
    output logic     data_ok_o,
    output logic     rd_req_o,
    output mem_rd_t  rd_o,
    input  logic     rd_rdy_i,
    input  logic     ret_valid_i,
    input  logic     ret_last_i,
    output cpu_req_t lookup_req_o,
    input  logic     hit0_i,
    input  logic     hit1_i,
    output logic     fill_we0_o,
    output logic     fill_we1_o,
    output logic     refill_start_o,
    output logic     sel_refill_o
);

    cache_state_e           state_q;
    cache_state_e           state_d;
    cpu_req_t               req_q;
    logic                   miss_q;        // current request went to memory
    logic [`CACHE_SETS-1:0] repl_q;        // way to fill next, per set
    logic                   accept;
    logic                   cached_hit;
    logic                   last_beat;
    logic                   fill_line;
    logic                   victim;

    assign accept     = valid_i && addr_ok_o;
    assign cached_hit = (hit0_i || hit1_i) && !req_q.uncached;
    assign last_beat  = (state_q == refill) && ret_valid_i && ret_last_i;
    assign fill_line  = last_beat && !req_q.uncached;   // uncached never allocates
    assign victim     = repl_q[req_q.index];

    //////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            idle: begin
                if (accept) begin
                    state_d = lookup;
                end
            end
            lookup: begin
                state_d = cached_hit ? done : miss;
            end
            miss: begin
                if (rd_rdy_i) begin      // command taken
                    state_d = refill;
                end
            end
            refill: begin
                if (last_beat) begin
                    state_d = done;
                end
            end
            default: begin
                state_d = idle;          // done lasts one cycle
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            state_q <= idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            req_q <= cpu_req_i;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            miss_q <= 1'b0;
        end else if (accept) begin
            miss_q <= 1'b0;
        end else if (state_q == lookup && !cached_hit) begin
            miss_q <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // replacement, ways of a set fill in turn
    //////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            repl_q <= '0;
        end else if (fill_line) begin
            repl_q[req_q.index] <= !victim;
        end
    end

    assign fill_we0_o = fill_line && !victim;
    assign fill_we1_o = fill_line && victim;

    // memory read command, held while in miss
    assign rd_req_o       = (state_q == miss);
    assign rd_o.rd_type   = req_q.uncached ? rd_word : rd_line;
    assign rd_o.addr      = {req_q.tag, req_q.index,
                             req_q.uncached ? req_q.offset : {`CACHE_OFFSET_W{1'b0}}};
    assign refill_start_o = (state_q == miss);

    // processor handshake
    assign addr_ok_o    = (state_q == idle);
    assign data_ok_o    = ((state_q == lookup) && cached_hit) || ((state_q == done) && miss_q);
    assign sel_refill_o = miss_q;
    assign lookup_req_o = req_q;

endmodule

//--- verilog/read_data_sel.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module read_data_sel import cache_pkg::*; (
    input  logic                         sel_refill_i,
    input  logic                         uncache_i,
    input  logic [`CACHE_WORD_SEL_W-1:0] word_i,
    input  logic                         hit0_i,
    input  logic                         hit1_i,
    input  cache_line_t                  way0_line_i,
    input  cache_line_t                  way1_line_i,
    input  cache_line_t                  refill_line_i,
    output logic [`CACHE_WORD_W-1:0]     rdata_o
);

    cache_line_t hit_line;

    assign hit_line = hit0_i ? way0_line_i : way1_line_i;   // way0 wins a double hit

    always_comb begin
        if (sel_refill_i) begin
            if (uncache_i) begin
                rdata_o = refill_line_i[0];                  // single beat lands in slot 0
            end else begin
                rdata_o = refill_line_i[word_i];
            end
        end else if (hit0_i || hit1_i) begin
            rdata_o = hit_line[word_i];
        end else begin
            rdata_o = '0;
        end
    end

endmodule

//--- verilog/refill_buffer.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module refill_buffer import cache_pkg::*; (
    input  logic                     aclk,
    input  logic                     rst_n_i,
    input  logic                     start_i,
    input  logic                     ret_valid_i,
    input  logic [`CACHE_WORD_W-1:0] ret_data_i,
    output cache_line_t              line_o
);

    logic [`CACHE_WORD_SEL_W-1:0] cnt_q;     // next slot to fill
    cache_line_t                  beat_q;

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (start_i) begin
            cnt_q <= '0;
        end else if (ret_valid_i) begin
            cnt_q <= cnt_q + 1'b1;           // wraps after a full line
        end
    end

    always_ff @(posedge aclk) begin
        if (ret_valid_i) begin
            beat_q[cnt_q] <= ret_data_i;
        end
    end

    // beat in flight shows up at once, so the way write
    // on the last beat sees the full line
    always_comb begin
        line_o = beat_q;
        if (ret_valid_i) begin
            line_o[cnt_q] = ret_data_i;
        end
    end

endmodule

//--- verilog/cache_way.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_way import cache_pkg::*; (
    input  logic                      aclk,
    input  logic                      rst_n_i,
    input  logic [`CACHE_INDEX_W-1:0] index_i,
    input  logic [`CACHE_TAG_W-1:0]   tag_i,
    output logic                      hit_o,
    output cache_line_t               line_o,
    input  logic                      we_i,
    input  cache_line_t               wr_line_i
);

    logic [`CACHE_SETS-1:0] valid_q;
    logic [`CACHE_TAG_W-1:0] tag_mem [0:`CACHE_SETS-1];
    cache_line_t             line_mem [0:`CACHE_SETS-1];

    //////////////////////////////////////////////////
    // lookup, combinational on the addressed set
    //////////////////////////////////////////////////
    assign hit_o  = valid_q[index_i] && (tag_mem[index_i] == tag_i);
    assign line_o = line_mem[index_i];

    // valid bits only drop at reset
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (we_i) begin
            valid_q[index_i] <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (we_i) begin
            tag_mem[index_i]  <= tag_i;
            line_mem[index_i] <= wr_line_i;    // whole line at once
        end
    end

endmodule

//--- verilog/cache_pkg.sv
`include "cache_consts.svh"

package cache_pkg;

    //////////////////////////////////////////////////
    // processor side
    //////////////////////////////////////////////////
    typedef struct packed {
        logic [`CACHE_TAG_W-1:0]    tag;
        logic [`CACHE_INDEX_W-1:0]  index;
        logic [`CACHE_OFFSET_W-1:0] offset;
        logic                       uncached;   // bypass, no allocate
    } cpu_req_t;

    //////////////////////////////////////////////////
    // memory side
    //////////////////////////////////////////////////
    typedef enum logic [`CACHE_RD_TYPE_W-1:0] {
        rd_word = `CACHE_RD_WORD,   // single beat
        rd_line = `CACHE_RD_LINE    // four beat burst
    } rd_type_e;

    typedef struct packed {
        rd_type_e                 rd_type;
        logic [`CACHE_ADDR_W-1:0] addr;
    } mem_rd_t;

    // word 0 sits in the low bits
    typedef logic [`CACHE_LINE_WORDS-1:0][`CACHE_WORD_W-1:0] cache_line_t;

    // controller states
    typedef enum logic [2:0] {
        idle,
        lookup,
        miss,
        refill,
        done
    } cache_state_e;

endpackage

//--- verilog/cache_consts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

//////////////////////////////////////////////////
// request fields
//////////////////////////////////////////////////
`define CACHE_TAG_W       20
`define CACHE_INDEX_W     8
`define CACHE_OFFSET_W    4             // byte offset inside a line
`define CACHE_ADDR_W      32            // tag + index + offset

//////////////////////////////////////////////////
// geometry
//////////////////////////////////////////////////
`define CACHE_SETS        256           // 2 ** index width
`define CACHE_WORD_W      32
`define CACHE_LINE_WORDS  4             // also beats per line refill
`define CACHE_WORD_SEL_W  2             // offset bits above the byte lane

// burst read types, 3 bit field as on the memory side
`define CACHE_RD_TYPE_W   3
`define CACHE_RD_WORD     3'd2
`define CACHE_RD_LINE     3'd4

`endif
